// File: flist.f
+incdir+.
fb_pkg.sv
sync_fifo.sv
write_port.sv
read_port.sv
mem_arbiter.sv
frame_mem.sv
fb_top.sv
fb_properties.sv
fb_tb.sv

// File: Bender.yml
package:
  name: frame_buffer

sources:
  - include_dirs:
      - .
    files:
      - fb_pkg.sv
      - sync_fifo.sv
      - write_port.sv
      - read_port.sv
      - mem_arbiter.sv
      - frame_mem.sv
      - fb_top.sv
      - target: test
        files:
          - fb_properties.sv
          - fb_tb.sv

// File: fb_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module fb_tb;
	import fb_pkg::*;

	localparam int WORDS          = 2 ** `FB_ADDR_W;
	localparam int TIMEOUT_CYCLES = 4000;             // Per wait loop
	localparam logic [31:0] LFSR_SEED = 32'hb0f6_4023;

	logic  REF_CLK;
	logic  RESET_N;
	logic  wr_push;
	data_t wr_wdata;
	logic  wr_full;
	logic  wr_load;
	addr_t wr_min_addr;
	addr_t wr_max_addr;
	len_t  wr_length;
	logic  rd_pop;
	data_t rd_rdata;
	logic  rd_empty;
	logic  rd_load;
	logic  rd_enable;
	addr_t rd_min_addr;
	addr_t rd_max_addr;
	len_t  rd_length;
	logic  ping_pong_en;

	// Model state
	data_t       model_mem [WORDS];       // Expected memory image
	bit          model_set [WORDS];       // Word written at least once
	data_t       pending [$];             // Words short of a full burst
	addr_t       wr_model_addr;           // Next write burst start
	addr_t       rd_model_addr;           // Current read burst start
	int          rd_model_pos;            // Word within read burst
	logic [31:0] lfsr;
	int          full_cycles;             // Cycles source saw wr_full
	int          fail_count;
	logic        check_en;
	int          check_target;
	int          checked;

	fb_top fb_top_i (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.wr_push(wr_push), .wr_wdata(wr_wdata), .wr_full(wr_full),
		.wr_load(wr_load), .wr_min_addr(wr_min_addr), .wr_max_addr(wr_max_addr),
		.wr_length(wr_length),
		.rd_pop(rd_pop), .rd_rdata(rd_rdata), .rd_empty(rd_empty),
		.rd_load(rd_load), .rd_enable(rd_enable),
		.rd_min_addr(rd_min_addr), .rd_max_addr(rd_max_addr),
		.rd_length(rd_length), .ping_pong_en(ping_pong_en)
	);

	bind mem_arbiter fb_properties fb_properties_i (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.wr_req(wr_req), .wr_ack(wr_ack), .rd_req(rd_req), .rd_ack(rd_ack),
		.mem_we(mem_we), .mem_re(mem_re)
	);

	initial
	begin
		REF_CLK = 1'b0;
		forever #10 REF_CLK = ~REF_CLK;       // 50 MHz
	end

	// ------------------------------------------------------------------------
	// Reference model
	function automatic addr_t next_burst_addr(addr_t a, int len, addr_t min_a,
		addr_t max_a, logic pp, logic follow, logic wbank);
		int region_end;
		region_end = int'({a[`FB_ADDR_W-1], max_a[`FB_ADDR_W-2:0]}) + 1;
		if (int'(a) + 2 * len <= region_end)
			return a + addr_t'(len);          // Room for one more burst
		if (!pp)
			return {a[`FB_ADDR_W-1], min_a[`FB_ADDR_W-2:0]};
		if (follow)
			return {~wbank, min_a[`FB_ADDR_W-2:0]};     // Reader avoids writer
		return {~a[`FB_ADDR_W-1], min_a[`FB_ADDR_W-2:0]};
	endfunction

	// Restart address after reset or load
	function automatic addr_t load_addr(addr_t min_a, logic pp, logic alternate);
		if (pp && alternate)
			return {~min_a[`FB_ADDR_W-1], min_a[`FB_ADDR_W-2:0]};
		return min_a;
	endfunction

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
	endfunction

	task automatic next_word(output data_t w);
		int i;
		w = '0;
		for (i = 0; i < `FB_DATA_W; i++)
		begin
			lfsr = lfsr_step(lfsr);
			w    = {w[`FB_DATA_W-2:0], lfsr[0]};
		end
	endtask

	task automatic report_failure(input string msg);
		fail_count++;
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Model lands words only once a whole burst is buffered
	task automatic commit_word(input data_t w);
		int i;
		pending.push_back(w);
		if (pending.size() == int'(wr_length))
		begin
			for (i = 0; i < pending.size(); i++)
			begin
				model_mem[wr_model_addr + addr_t'(i)] = pending[i];
				model_set[wr_model_addr + addr_t'(i)] = 1'b1;
			end
			wr_model_addr = next_burst_addr(wr_model_addr, int'(wr_length),
				wr_min_addr, wr_max_addr, ping_pong_en, 1'b0, 1'b0);
			pending.delete();
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus helpers
	task automatic configure(input logic pp, input addr_t wmin, input addr_t wmax,
		input len_t wlen, input addr_t rmin, input addr_t rmax, input len_t rlen);
		@(negedge REF_CLK);
		ping_pong_en = pp;
		wr_min_addr  = wmin;
		wr_max_addr  = wmax;
		wr_length    = wlen;
		rd_min_addr  = rmin;
		rd_max_addr  = rmax;
		rd_length    = rlen;
	endtask

	task automatic restart_ports(input logic wr, input logic rd);
		@(negedge REF_CLK);
		wr_load = wr;
		rd_load = rd;
		@(negedge REF_CLK);
		wr_load = 1'b0;
		rd_load = 1'b0;
		if (wr)
		begin
			pending.delete();                 // FIFO flushed
			wr_model_addr = load_addr(wr_min_addr, ping_pong_en, 1'b0);
		end
		if (rd)
		begin
			rd_model_addr = load_addr(rd_min_addr, ping_pong_en, 1'b1);
			rd_model_pos  = 0;
			assert (rd_empty)
				else report_failure("read FIFO still holds data after rd_load");
		end
	endtask

	// Source holds a word until wr_full is low
	task automatic push_words(input int n);
		int    sent;
		int    stall;
		logic  have_word;
		data_t w;
		sent      = 0;
		stall     = 0;
		have_word = 1'b0;
		w         = '0;
		while (sent < n)
		begin
			@(negedge REF_CLK);
			if (!have_word)
			begin
				next_word(w);
				have_word = 1'b1;
			end
			wr_wdata = w;
			wr_push  = 1'b1;
			if (wr_full)                          // Ignored this cycle
			begin
				full_cycles++;
				stall++;
				assert (stall < TIMEOUT_CYCLES)
					else report_failure("write FIFO stayed full, source stalled");
			end
			else
			begin
				commit_word(w);
				have_word = 1'b0;
				sent++;
				stall = 0;
			end
		end
		@(negedge REF_CLK);
		wr_push = 1'b0;
	endtask

	task automatic wait_write_drain();
		int cycles;
		cycles = 0;
		@(negedge REF_CLK);
		while ((fb_top_i.write_port_i.wr_count != '0) || fb_top_i.wr_req
			|| fb_top_i.wr_ack)
		begin
			cycles++;
			assert (cycles < TIMEOUT_CYCLES)
				else report_failure("timeout waiting for write FIFO to drain");
			@(negedge REF_CLK);
		end
	endtask

	task automatic wait_read_idle();
		int cycles;
		cycles = 0;
		@(negedge REF_CLK);
		while (fb_top_i.rd_req || fb_top_i.rd_ack)  // Burst in flight
		begin
			cycles++;
			assert (cycles < TIMEOUT_CYCLES)
				else report_failure("timeout waiting for read burst to finish");
			@(negedge REF_CLK);
		end
	endtask

	task automatic wait_read_data();
		int cycles;
		cycles = 0;
		@(negedge REF_CLK);
		while (rd_empty)
		begin
			cycles++;
			assert (cycles < TIMEOUT_CYCLES)
				else report_failure("timeout waiting for read FIFO data");
			@(negedge REF_CLK);
		end
	endtask

	// Enable reads, let the checker take n words, then park the reader
	task automatic read_and_check(input int n);
		int cycles;
		cycles = 0;
		@(negedge REF_CLK);
		rd_enable = 1'b1;
		@(posedge REF_CLK);
		checked      = 0;
		check_target = n;
		check_en     = 1'b1;
		while (checked < n)
		begin
			@(posedge REF_CLK);
			cycles++;
			assert (cycles < TIMEOUT_CYCLES)
				else report_failure("timeout waiting for read stream words");
		end
		check_en = 1'b0;
		@(negedge REF_CLK);
		rd_enable = 1'b0;
		wait_read_idle();
	endtask

	// ------------------------------------------------------------------------
	// Checker that pops and compares the read stream
	always @(negedge REF_CLK)
	begin : compare_stream
		addr_t exp_addr;
		if (check_en && !rd_empty && (checked < check_target))
		begin
			exp_addr = rd_model_addr + addr_t'(rd_model_pos);
			assert (model_set[exp_addr])
				else report_failure($sformatf("read of address 0x%03h never written",
					exp_addr));
			assert (rd_rdata === model_mem[exp_addr])
				else report_failure($sformatf(
					"mismatch rd_rdata at 0x%03h: expected 0x%08h, got 0x%08h",
					exp_addr, model_mem[exp_addr], rd_rdata));
			rd_pop = 1'b1;
			checked++;
			rd_model_pos++;
			if (rd_model_pos == int'(rd_length))     // Burst boundary
			begin
				rd_model_addr = next_burst_addr(rd_model_addr, int'(rd_length),
					rd_min_addr, rd_max_addr, ping_pong_en, 1'b1,
					wr_model_addr[`FB_ADDR_W-1]);
				rd_model_pos  = 0;
			end
		end
		else
			rd_pop = 1'b0;
	end

	// ------------------------------------------------------------------------
	// Main sequence
	initial
	begin
		RESET_N      = 1'b0;
		wr_push      = 1'b0;
		wr_wdata     = '0;
		wr_load      = 1'b0;
		wr_min_addr  = '0;
		wr_max_addr  = 12'h03f;
		wr_length    = 6'd16;
		rd_pop       = 1'b0;
		rd_load      = 1'b0;
		rd_enable    = 1'b0;
		rd_min_addr  = '0;
		rd_max_addr  = 12'h03f;
		rd_length    = 6'd8;
		ping_pong_en = 1'b0;
		lfsr         = LFSR_SEED;
		full_cycles  = 0;
		fail_count   = 0;
		check_en     = 1'b0;
		check_target = 0;
		checked      = 0;
		rd_model_pos = 0;
		repeat (8) @(posedge REF_CLK);
		@(negedge REF_CLK);
		RESET_N = 1'b1;
		assert (!wr_full)
			else report_failure("wr_full is high right after reset");
		assert (rd_empty)
			else report_failure("rd_empty is low right after reset");

		// Single region written with reads gated and then read in order
		configure(1'b0, 12'h000, 12'h03f, 6'd16, 12'h000, 12'h03f, 6'd8);
		restart_ports(1'b1, 1'b1);
		push_words(64);
		wait_write_drain();
		read_and_check(64);

		// Writer wraps to wr_min_addr and overwrites
		push_words(80);
		wait_write_drain();
		restart_ports(1'b0, 1'b1);
		read_and_check(64);

		// Writer ends in bank 1 so each reader wrap lands in bank 0
		configure(1'b1, 12'h000, 12'h03f, 6'd16, 12'h000, 12'h03f, 6'd8);
		restart_ports(1'b1, 1'b1);
		push_words(192);
		wait_write_drain();
		read_and_check(192);

		// Single-word bursts drain slower than the source fills
		configure(1'b0, 12'h000, 12'h0ff, 6'd1, 12'h000, 12'h0ff, 6'd32);
		restart_ports(1'b1, 1'b1);
		full_cycles = 0;
		push_words(256);
		wait_write_drain();
		assert (full_cycles > 0)
			else report_failure("write FIFO never filled, no back-pressure seen");
		read_and_check(256);

		// Loads with data parked in both FIFOs
		@(negedge REF_CLK);
		rd_enable = 1'b1;
		wait_read_data();
		rd_enable = 1'b0;
		wait_read_idle();
		configure(1'b1, 12'h000, 12'h03f, 6'd16, 12'h000, 12'h03f, 6'd8);
		push_words(10);                           // Short of one burst
		restart_ports(1'b1, 1'b1);
		push_words(128);
		wait_write_drain();
		read_and_check(64);

		if (fail_count == 0)
		begin
			$display("Simulation completed successfully");
			$finish;
		end
		else
		begin
			$display("Simulation failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: fb_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fb_properties (
	input  wire logic REF_CLK,
	input  wire logic RESET_N,
	input  wire logic wr_req,
	input  wire logic wr_ack,
	input  wire logic rd_req,
	input  wire logic rd_ack,
	input  wire logic mem_we,
	input  wire logic mem_re
);

	// ------------------------------------------------------------------------
	// Four-phase handshake, write side
	wr_ack_needs_req: assert property (@(posedge REF_CLK) disable iff (!RESET_N)
		$rose(wr_ack) |-> wr_req)
		else $error("wr_ack rose while wr_req was low");

	wr_req_held: assert property (@(posedge REF_CLK) disable iff (!RESET_N)
		$fell(wr_req) |-> $past(wr_ack))                  // Drop only after ack
		else $error("wr_req dropped before wr_ack");

	// ------------------------------------------------------------------------
	// Four-phase handshake, read side
	rd_ack_needs_req: assert property (@(posedge REF_CLK) disable iff (!RESET_N)
		$rose(rd_ack) |-> rd_req)
		else $error("rd_ack rose while rd_req was low");

	rd_req_held: assert property (@(posedge REF_CLK) disable iff (!RESET_N)
		$fell(rd_req) |-> $past(rd_ack))
		else $error("rd_req dropped before rd_ack");

	// Single-port memory, one access per cycle
	mem_one_access: assert property (@(posedge REF_CLK) disable iff (!RESET_N)
		!(mem_we && mem_re))
		else $error("mem_we and mem_re asserted together");

endmodule

`default_nettype wire

// File: fb_top.sv
`timescale 1ns/1ps
`default_nettype none

module fb_top (
	input  wire logic          REF_CLK,
	input  wire logic          RESET_N,
	input  wire logic          wr_push,
	input  wire fb_pkg::data_t wr_wdata,
	output logic               wr_full,
	input  wire logic          wr_load,
	input  wire fb_pkg::addr_t wr_min_addr,
	input  wire fb_pkg::addr_t wr_max_addr,
	input  wire fb_pkg::len_t  wr_length,
	input  wire logic          rd_pop,
	output fb_pkg::data_t      rd_rdata,
	output logic               rd_empty,
	input  wire logic          rd_load,
	input  wire logic          rd_enable,
	input  wire fb_pkg::addr_t rd_min_addr,
	input  wire fb_pkg::addr_t rd_max_addr,
	input  wire fb_pkg::len_t  rd_length,
	input  wire logic          ping_pong_en
);
	import fb_pkg::*;

	// Write port handshake
	logic  wr_req;
	logic  wr_ack;
	addr_t wr_addr;
	len_t  wr_len;
	logic  wr_pop;
	data_t wr_data;
	logic  wr_bank;        // Bank hint to reader

	// Read port handshake
	logic  rd_req;
	logic  rd_ack;
	addr_t rd_addr;
	len_t  rd_len;
	logic  rd_push;
	data_t rd_data;

	// Memory bus
	logic  mem_we;
	logic  mem_re;
	addr_t mem_addr;
	data_t mem_wdata;
	data_t mem_rdata;

	write_port write_port_i (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.wr_push(wr_push), .wr_wdata(wr_wdata), .wr_full(wr_full),
		.wr_load(wr_load), .wr_min_addr(wr_min_addr), .wr_max_addr(wr_max_addr),
		.wr_length(wr_length), .ping_pong_en(ping_pong_en),
		.wr_req(wr_req), .wr_ack(wr_ack), .wr_addr(wr_addr), .wr_len(wr_len),
		.wr_pop(wr_pop), .wr_data(wr_data), .wr_bank(wr_bank)
	);

	read_port read_port_i (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.rd_pop(rd_pop), .rd_rdata(rd_rdata), .rd_empty(rd_empty),
		.rd_load(rd_load), .rd_enable(rd_enable),
		.rd_min_addr(rd_min_addr), .rd_max_addr(rd_max_addr),
		.rd_length(rd_length), .ping_pong_en(ping_pong_en), .wr_bank(wr_bank),
		.rd_req(rd_req), .rd_ack(rd_ack), .rd_addr(rd_addr), .rd_len(rd_len),
		.rd_push(rd_push), .rd_data(rd_data)
	);

	mem_arbiter mem_arbiter_i (
		.REF_CLK(REF_CLK), .RESET_N(RESET_N),
		.wr_req(wr_req), .wr_ack(wr_ack), .wr_addr(wr_addr), .wr_len(wr_len),
		.wr_pop(wr_pop), .wr_data(wr_data),
		.rd_req(rd_req), .rd_ack(rd_ack), .rd_addr(rd_addr), .rd_len(rd_len),
		.rd_push(rd_push), .rd_data(rd_data),
		.mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

	frame_mem frame_mem_i (
		.REF_CLK(REF_CLK),
		.mem_we(mem_we), .mem_re(mem_re), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: frame_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module frame_mem (
	input  wire logic          REF_CLK,
	input  wire logic          mem_we,
	input  wire logic          mem_re,
	input  wire fb_pkg::addr_t mem_addr,
	input  wire fb_pkg::data_t mem_wdata,
	output fb_pkg::data_t      mem_rdata     // Valid cycle after mem_re
);
	import fb_pkg::*;

	localparam int WORDS = 2 ** `FB_ADDR_W;  // Both banks

	data_t mem_array [WORDS];

	// Single port, write or read per cycle
	always_ff @(posedge REF_CLK)
	begin
		if (mem_we)
			mem_array[mem_addr] <= mem_wdata;
		if (mem_re)
			mem_rdata <= mem_array[mem_addr];   // Registered read
	end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire logic          REF_CLK,
	input  wire logic          RESET_N,
	input  wire logic          wr_req,
	output logic               wr_ack,
	input  wire fb_pkg::addr_t wr_addr,
	input  wire fb_pkg::len_t  wr_len,
	output logic               wr_pop,     // FIFO advance
	input  wire fb_pkg::data_t wr_data,
	input  wire logic          rd_req,
	output logic               rd_ack,
	input  wire fb_pkg::addr_t rd_addr,
	input  wire fb_pkg::len_t  rd_len,
	output logic               rd_push,    // Read strobe, one cycle late
	output fb_pkg::data_t      rd_data,
	output logic               mem_we,
	output logic               mem_re,
	output fb_pkg::addr_t      mem_addr,
	output fb_pkg::data_t      mem_wdata,
	input  wire fb_pkg::data_t mem_rdata
);
	import fb_pkg::*;

	arb_state_t state;
	len_t       word_cnt;      // Words issued so far
	len_t       burst_len;     // Captured from port
	addr_t      burst_addr;    // Running memory address

	// Memory strobes straight from state
	assign mem_we    = (state == WR_BURST);
	assign mem_re    = (state == RD_BURST) && (word_cnt != burst_len);
	assign mem_addr  = burst_addr;
	assign mem_wdata = wr_data;             // FIFO head
	assign wr_pop    = mem_we;
	assign rd_data   = mem_rdata;           // Aligned with rd_push

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state      <= IDLE;
			word_cnt   <= '0;
			burst_len  <= '0;
			burst_addr <= '0;
			wr_ack     <= 1'b0;
			rd_ack     <= 1'b0;
			rd_push    <= 1'b0;
		end
		else
		begin
			rd_push <= mem_re;              // Memory read latency
			case (state)
			IDLE:
				begin
					word_cnt <= '0;
					if (wr_req && !wr_ack)          // Write first
					begin
						burst_addr <= wr_addr;
						burst_len  <= wr_len;
						state      <= WR_BURST;
					end
					else if (rd_req && !rd_ack)
					begin
						burst_addr <= rd_addr;
						burst_len  <= rd_len;
						state      <= RD_BURST;
					end
				end
			WR_BURST:
				begin
					burst_addr <= burst_addr + 1'b1;
					word_cnt   <= word_cnt + 1'b1;
					if (word_cnt == burst_len - 1'b1)    // Last word
					begin
						wr_ack <= 1'b1;
						state  <= ACK_WAIT;
					end
				end
			RD_BURST:
				begin
					if (word_cnt == burst_len)           // Last push now
					begin
						rd_ack <= 1'b1;
						state  <= ACK_WAIT;
					end
					else
					begin
						burst_addr <= burst_addr + 1'b1;
						word_cnt   <= word_cnt + 1'b1;
					end
				end
			ACK_WAIT:
				begin
					if (wr_ack && !wr_req)               // Req released
					begin
						wr_ack <= 1'b0;
						state  <= IDLE;
					end
					else if (rd_ack && !rd_req)
					begin
						rd_ack <= 1'b0;
						state  <= IDLE;
					end
				end
			default:
				state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: read_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module read_port (
	input  wire logic          REF_CLK,
	input  wire logic          RESET_N,
	input  wire logic          rd_pop,       // Sink takes head
	output fb_pkg::data_t      rd_rdata,
	output logic               rd_empty,
	input  wire logic          rd_load,      // Restart address, flush FIFO
	input  wire logic          rd_enable,    // Read gate
	input  wire fb_pkg::addr_t rd_min_addr,
	input  wire fb_pkg::addr_t rd_max_addr,
	input  wire fb_pkg::len_t  rd_length,
	input  wire logic          ping_pong_en,
	input  wire logic          wr_bank,      // Writer's current bank
	output logic               rd_req,
	input  wire logic          rd_ack,
	output fb_pkg::addr_t      rd_addr,
	output fb_pkg::len_t       rd_len,
	input  wire logic          rd_push,      // Word back from memory
	input  wire fb_pkg::data_t rd_data
);
	import fb_pkg::*;

	cnt_t  rd_count;       // Words buffered
	cnt_t  rd_free;        // Room left
	logic  init_pend;      // Reload address after reset
	addr_t own_start;      // Start of active region
	addr_t opp_start;      // Region opposite writer
	addr_t load_start;     // Reset and load target
	logic  addr_fits;

	// -------------------------------------------------------------------------
	// Read FIFO
	sync_fifo #(
		.DEPTH     (`FB_FIFO_DEPTH)
	) rd_fifo_i (
		.REF_CLK   (REF_CLK),
		.RESET_N   (RESET_N),
		.clear     (rd_load),
		.push      (rd_push),
		.push_data (rd_data),
		.pop       (rd_pop),
		.pop_data  (rd_rdata),
		.count     (rd_count),
		.full      (),
		.empty     (rd_empty)
	);

	assign rd_free = cnt_t'(`FB_FIFO_DEPTH) - rd_count;

	// -------------------------------------------------------------------------
	// Address generator, follows writer in ping-pong mode
	assign own_start  = {rd_addr[`FB_ADDR_W-1], rd_min_addr[`FB_ADDR_W-2:0]};
	assign opp_start  = {~wr_bank, rd_min_addr[`FB_ADDR_W-2:0]};
	assign load_start = ping_pong_en ?
		{~rd_min_addr[`FB_ADDR_W-1], rd_min_addr[`FB_ADDR_W-2:0]} : rd_min_addr;
	assign addr_fits  = burst_fits(rd_addr, rd_len, rd_max_addr);

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			init_pend <= 1'b1;
			rd_addr   <= '0;
		end
		else if (init_pend || rd_load)
		begin
			init_pend <= 1'b0;
			rd_addr   <= load_start;               // Alternate region first
		end
		else if (rd_req && rd_ack)
		begin
			if (addr_fits)
				rd_addr <= rd_addr + addr_t'(rd_len);
			else if (ping_pong_en)
				rd_addr <= opp_start;              // Bank writer left
			else
				rd_addr <= own_start;
		end
	end

	// -------------------------------------------------------------------------
	// Burst requester
	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			rd_req <= 1'b0;
			rd_len <= '0;
		end
		else if (rd_req)
		begin
			if (rd_ack)
				rd_req <= 1'b0;
		end
		else if (!rd_ack && rd_enable && !rd_load && !init_pend
			&& (rd_length != '0) && (rd_free >= cnt_t'(rd_length)))   // Room for burst
		begin
			rd_req <= 1'b1;
			rd_len <= rd_length;
		end
	end

endmodule

`default_nettype wire

// File: write_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module write_port (
	input  wire logic          REF_CLK,
	input  wire logic          RESET_N,
	input  wire logic          wr_push,      // Source word valid
	input  wire fb_pkg::data_t wr_wdata,
	output logic               wr_full,      // Source must hold
	input  wire logic          wr_load,      // Restart address, flush FIFO
	input  wire fb_pkg::addr_t wr_min_addr,
	input  wire fb_pkg::addr_t wr_max_addr,
	input  wire fb_pkg::len_t  wr_length,
	input  wire logic          ping_pong_en,
	output logic               wr_req,
	input  wire logic          wr_ack,
	output fb_pkg::addr_t      wr_addr,
	output fb_pkg::len_t       wr_len,
	input  wire logic          wr_pop,       // One word per pulse
	output fb_pkg::data_t      wr_data,
	output logic               wr_bank       // To reader
);
	import fb_pkg::*;

	cnt_t  wr_count;       // Words waiting
	logic  init_pend;      // Reload address after reset
	addr_t own_start;      // Start of active region
	addr_t alt_start;      // Start of other region
	logic  addr_fits;      // Another burst fits above

	// -------------------------------------------------------------------------
	// Write FIFO
	sync_fifo #(
		.DEPTH     (`FB_FIFO_DEPTH)
	) wr_fifo_i (
		.REF_CLK   (REF_CLK),
		.RESET_N   (RESET_N),
		.clear     (wr_load),
		.push      (wr_push),
		.push_data (wr_wdata),
		.pop       (wr_pop),
		.pop_data  (wr_data),          // Head straight to arbiter
		.count     (wr_count),
		.full      (wr_full),
		.empty     ()
	);

	// -------------------------------------------------------------------------
	// Address generator with ping-pong
	assign wr_bank   = wr_addr[`FB_ADDR_W-1];
	assign own_start = {wr_addr[`FB_ADDR_W-1], wr_min_addr[`FB_ADDR_W-2:0]};
	assign alt_start = {~wr_addr[`FB_ADDR_W-1], wr_min_addr[`FB_ADDR_W-2:0]};
	assign addr_fits = burst_fits(wr_addr, wr_len, wr_max_addr);

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			init_pend <= 1'b1;
			wr_addr   <= '0;
		end
		else if (init_pend || wr_load)
		begin
			init_pend <= 1'b0;
			wr_addr   <= wr_min_addr;
		end
		else if (wr_req && wr_ack)                     // Burst done
		begin
			if (addr_fits)
				wr_addr <= wr_addr + addr_t'(wr_len);
			else if (ping_pong_en)
				wr_addr <= alt_start;                  // Swap bank
			else
				wr_addr <= own_start;                  // Stay in bank
		end
	end

	// -------------------------------------------------------------------------
	// Burst requester, four-phase
	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wr_req <= 1'b0;
			wr_len <= '0;
		end
		else if (wr_req)
		begin
			if (wr_ack)
				wr_req <= 1'b0;                        // Ack seen
		end
		else if (!wr_ack && !wr_load && !init_pend && (wr_length != '0)
			&& (wr_count >= cnt_t'(wr_length)))        // Full burst waiting
		begin
			wr_req <= 1'b1;
			wr_len <= wr_length;                       // Held for burst
		end
	end

endmodule

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "fb_defines.svh"

module sync_fifo #(
	parameter int DEPTH = `FB_FIFO_DEPTH    // Power of two
) (
	input  wire logic          REF_CLK,
	input  wire logic          RESET_N,
	input  wire logic          clear,       // Sync flush
	input  wire logic          push,
	input  wire fb_pkg::data_t push_data,
	input  wire logic          pop,
	output fb_pkg::data_t      pop_data,    // Head word, show-ahead
	output fb_pkg::cnt_t       count,
	output logic               full,
	output logic               empty
);
	import fb_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	data_t            buf_mem [DEPTH];     // Circular storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;        // Push while full is dropped
	assign do_pop   = pop && !empty;
	assign full     = (count == cnt_t'(DEPTH));
	assign empty    = (count == '0);
	assign pop_data = buf_mem[rd_ptr];

	always_ff @(posedge REF_CLK)
	begin
		if (do_push && !clear)
			buf_mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge REF_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (clear)                     // Load restart
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + PTR_W'(do_push);   // Wraps at DEPTH
			rd_ptr <= rd_ptr + PTR_W'(do_pop);
			count  <= count + cnt_t'(do_push) - cnt_t'(do_pop);
		end
	end

endmodule

`default_nettype wire

// File: fb_pkg.sv
`default_nettype none
`include "fb_defines.svh"

package fb_pkg;

	typedef logic [`FB_DATA_W-1:0] data_t;   // One memory word
	typedef logic [`FB_ADDR_W-1:0] addr_t;   // Word address
	typedef logic [`FB_LEN_W-1:0]  len_t;    // Burst length in words
	typedef logic [`FB_CNT_W-1:0]  cnt_t;    // FIFO fill level

	typedef enum logic [1:0] {
		IDLE,        // No burst running
		WR_BURST,    // Write FIFO to memory
		RD_BURST,    // Memory to read FIFO
		ACK_WAIT     // Ack high, waiting on req low
	} arb_state_t;

	// Next burst of l words after a still ends inside a's region
	function automatic logic burst_fits(addr_t a, len_t l, addr_t max_addr);
		logic [`FB_ADDR_W+1:0] next_end;
		logic [`FB_ADDR_W+1:0] region_lim;
		next_end   = {2'b00, a} + {l, 1'b0};                   // a + 2L
		region_lim = {2'b00, a[`FB_ADDR_W-1], max_addr[`FB_ADDR_W-2:0]} + 1'b1;
		return next_end <= region_lim;
	endfunction

endpackage

`default_nettype wire

// File: fb_defines.svh
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// ---------------------------------------------------------------------------
// Frame buffer widths and depths

// Data path
`define FB_DATA_W      32    // Bits per memory word

// Word address, top bit is the ping-pong bank
`define FB_ADDR_W      12

// Burst length field, bursts of 1 to 63 words
`define FB_LEN_W       6

// FIFO sizing
`define FB_FIFO_DEPTH  128   // Holds two largest bursts
`define FB_CNT_W       8     // Fill count, 0 to FB_FIFO_DEPTH

`endif
